/* design/frontEnd_defines.svh */
//**************************************************
// Front end sizes
// Widths, reset address and table sizes
//**************************************************
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// Data and address width
`define XLEN 32

// Fetch address after reset
`define PC_START 32'h0000_0000

// BTB geometry, index taken from PC bits above the byte offset
`define BTB_ENTRIES 32
`define BTB_IDX_BITS 5

// History length, also the counter table index width
`define GHR_BITS 5

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

/* design/rvIsaPkg.sv */
//**************************************************
// RISC-V ISA types
// Opcodes, immediate formats and field layout
//**************************************************
package rvIsaPkg;

    // RV32I major opcodes used by the front end
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opItype  = 7'b0010011,
        opRtype  = 7'b0110011
    } opcodeT;

    typedef enum logic [2:0] {
        immNone,
        immI,
        immS,
        immB,
        immJ,
        immU
    } immFormT;

    // Overlay of a 32-bit instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } instrFieldsT;

    // Opcodes that write rd
    function automatic logic writesRd(opcodeT op);
        case (op)
            opLui, opJal, opJalr, opLoad, opItype, opRtype: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

/* design/frontEndPkg.sv */
//**************************************************
// Front end pipeline types
// Resolve, prediction and decoded slot structs
//**************************************************
`include "frontEnd_defines.svh"

package frontEndPkg;
    import rvIsaPkg::*;

    typedef enum logic [1:0] {
        kindNone,
        kindCond,
        kindJump
    } branchKindT;

    // Outcome of a branch or jump from the back end
    typedef struct packed {
        logic                 valid;
        branchKindT           kind;
        logic [`XLEN-1:0]     pc;
        logic [`XLEN-1:0]     target;
        logic                 actualTaken;
        logic                 predTaken;
        logic [`GHR_BITS-1:0] phtIndex;
    } resolveT;

    typedef struct packed {
        logic                 taken;
        logic [`XLEN-1:0]     target;
        logic [`GHR_BITS-1:0] phtIndex;
    } predictionT;

    // One decoded issue slot
    typedef struct packed {
        logic                 valid;
        instrFieldsT          instr;
        logic [`XLEN-1:0]     pc;
        logic [`XLEN-1:0]     imm;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [4:0]           rd;
        logic                 regWrite;
        logic                 predTaken;
        logic [`GHR_BITS-1:0] phtIndex;
    } decodedSlotT;

endpackage

/* design/branchPredictor.sv */
//**************************************************
// Branch predictor
// Tagged BTB, 2-bit counters and global history
//**************************************************
`timescale 1ns/1ps
`include "frontEnd_defines.svh"

module branchPredictor
    import rvIsaPkg::*;
    import frontEndPkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] pcF_i,
    input  opcodeT           opF_i,
    input  logic             fetchAdvance_i,
    input  resolveT          resolve_i,
    input  logic             mispredict_i,
    output predictionT       predF_o
);

    logic                                btbValid  [`BTB_ENTRIES];
    logic [`XLEN-`BTB_IDX_BITS-3:0]      btbTag    [`BTB_ENTRIES];
    logic [`XLEN-1:0]                    btbTarget [`BTB_ENTRIES];
    logic [1:0]                          pht       [1 << `GHR_BITS];
    logic [`GHR_BITS-1:0]                ghr;

    logic [`BTB_IDX_BITS-1:0] fetchIdx;
    logic [`BTB_IDX_BITS-1:0] resolveIdx;
    logic [`GHR_BITS-1:0]     fetchPht;
    logic                     btbHit;
    logic                     isBranchF;
    logic                     isJumpF;
    logic                     predTaken;
    logic                     phtUpdate;
    logic                     btbWrite;

    // Lookup for the fetch PC
    assign fetchIdx  = pcF_i[`BTB_IDX_BITS+1:2];
    assign fetchPht  = ghr ^ pcF_i[`GHR_BITS+1:2];
    assign btbHit    = btbValid[fetchIdx] &&
                       (btbTag[fetchIdx] == pcF_i[`XLEN-1:`BTB_IDX_BITS+2]);
    assign isBranchF = (opF_i == opBranch);
    assign isJumpF   = (opF_i == opJal) || (opF_i == opJalr);
    // Jumps need only a BTB hit, branches also the counter
    assign predTaken = btbHit && ((isBranchF && pht[fetchPht][1]) || isJumpF);

    assign predF_o.taken    = predTaken;
    assign predF_o.target   = btbTarget[fetchIdx];
    assign predF_o.phtIndex = fetchPht;

    // Update side from the resolve struct
    assign resolveIdx = resolve_i.pc[`BTB_IDX_BITS+1:2];
    assign phtUpdate  = resolve_i.valid && (resolve_i.kind != kindJump);
    assign btbWrite   = resolve_i.valid && resolve_i.actualTaken;

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                btbValid[i] <= 1'b0;
            end
            for (int i = 0; i < (1 << `GHR_BITS); i++) begin
                pht[i] <= 2'b00;
            end
        end else begin
            // Wrong path history is thrown away
            if (mispredict_i) begin
                ghr <= '0;
            end else if (fetchAdvance_i && isBranchF) begin
                ghr <= {ghr[`GHR_BITS-2:0], predTaken};
            end
            // Saturating counter toward the actual direction
            if (phtUpdate) begin
                if (resolve_i.actualTaken && (pht[resolve_i.phtIndex] != 2'b11)) begin
                    pht[resolve_i.phtIndex] <= pht[resolve_i.phtIndex] + 2'b01;
                end else if (!resolve_i.actualTaken && (pht[resolve_i.phtIndex] != 2'b00)) begin
                    pht[resolve_i.phtIndex] <= pht[resolve_i.phtIndex] - 2'b01;
                end
            end
            if (btbWrite) begin
                btbValid[resolveIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (btbWrite) begin
            btbTag[resolveIdx]    <= resolve_i.pc[`XLEN-1:`BTB_IDX_BITS+2];
            btbTarget[resolveIdx] <= resolve_i.target;
        end
    end

endmodule

/* design/issuePairCheck.sv */
//**************************************************
// Issue pair check
// Decides whether both fetched words may issue
//**************************************************
`timescale 1ns/1ps

module issuePairCheck
    import rvIsaPkg::*;
(
    input  instrFieldsT instrF_i,
    input  instrFieldsT instrF2_i,
    input  logic        predTakenF_i,
    output logic        pairBreak_o
);

    logic regWrite1;
    logic regWrite2;
    logic readsRs2;
    logic rawHazard;
    logic wawHazard;
    logic ctrlSlot2;

    assign regWrite1 = writesRd(instrF_i.opcode);
    assign regWrite2 = writesRd(instrF2_i.opcode);

    // Only R-type and stores read rs2 in slot 2
    assign readsRs2 = (instrF2_i.opcode == opRtype) || (instrF2_i.opcode == opStore);

    // x0 never creates a dependency
    assign rawHazard = regWrite1 && (instrF_i.rd != 5'd0) &&
                       ((instrF2_i.rs1 == instrF_i.rd) ||
                        (readsRs2 && (instrF2_i.rs2 == instrF_i.rd)));

    assign wawHazard = regWrite1 && regWrite2 && (instrF_i.rd != 5'd0) &&
                       (instrF_i.rd == instrF2_i.rd);

    // Control flow is only allowed in slot 1
    assign ctrlSlot2 = (instrF2_i.opcode == opBranch) ||
                       (instrF2_i.opcode == opJal) ||
                       (instrF2_i.opcode == opJalr);

    assign pairBreak_o = rawHazard || wawHazard || predTakenF_i || ctrlSlot2;

endmodule

/* design/immDecode.sv */
//**************************************************
// Immediate decoder
// Opcode-selected RISC-V immediate extraction
//**************************************************
`timescale 1ns/1ps
`include "frontEnd_defines.svh"

module immDecode
    import rvIsaPkg::*;
(
    input  instrFieldsT      instr_i,
    output logic [`XLEN-1:0] imm_o
);

    logic [31:0] word;
    immFormT     form;

    assign word = instr_i;

    always_comb begin
        case (instr_i.opcode)
            opLoad, opItype, opJalr: form = immI;
            opStore:                 form = immS;
            opBranch:                form = immB;
            opJal:                   form = immJ;
            opLui:                   form = immU;
            default:                 form = immNone;
        endcase
    end

    // Sign bit is always instruction bit 31
    always_comb begin
        case (form)
            immI:    imm_o = {{20{word[31]}}, word[31:20]};
            immS:    imm_o = {{20{word[31]}}, word[31:25], word[11:7]};
            immB:    imm_o = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
            immJ:    imm_o = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
            immU:    imm_o = {word[31:12], 12'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

/* design/decodeStage.sv */
//**************************************************
// Decode stage
// Fetch-to-decode registers for both issue slots
//**************************************************
`timescale 1ns/1ps
`include "frontEnd_defines.svh"

module decodeStage
    import rvIsaPkg::*;
    import frontEndPkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             stallD_i,
    input  logic             flushD_i,
    input  logic             pairBreak_i,
    input  instrFieldsT      instrF_i,
    input  instrFieldsT      instrF2_i,
    input  logic [`XLEN-1:0] pcF_i,
    input  predictionT       predF_i,
    output decodedSlotT      slotD_o,
    output decodedSlotT      slot2D_o
);

    logic                 validD;
    logic                 valid2D;
    logic                 predTakenD;
    instrFieldsT          instrD;
    instrFieldsT          instr2D;
    logic [`XLEN-1:0]     pcD;
    logic [`XLEN-1:0]     pc2D;
    logic [`XLEN-1:0]     immD;
    logic [`XLEN-1:0]     imm2D;
    logic [`GHR_BITS-1:0] phtIndexD;

    // Flush wins over stall
    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            validD     <= 1'b0;
            valid2D    <= 1'b0;
            predTakenD <= 1'b0;
            instrD     <= `NOP_INSTR;
            instr2D    <= `NOP_INSTR;
        end else if (!stallD_i) begin
            validD     <= 1'b1;
            predTakenD <= predF_i.taken;
            instrD     <= instrF_i;
            // Broken pair leaves a bubble in slot 2
            if (pairBreak_i) begin
                valid2D <= 1'b0;
                instr2D <= `NOP_INSTR;
            end else begin
                valid2D <= 1'b1;
                instr2D <= instrF2_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD_i) begin
            pcD       <= pcF_i;
            pc2D      <= pcF_i + `XLEN'd4;
            phtIndexD <= predF_i.phtIndex;
        end
    end

    immDecode immSlot1 (
        .instr_i (instrD),
        .imm_o   (immD)
    );

    immDecode immSlot2 (
        .instr_i (instr2D),
        .imm_o   (imm2D)
    );

    always_comb begin
        slotD_o.valid     = validD;
        slotD_o.instr     = instrD;
        slotD_o.pc        = pcD;
        slotD_o.imm       = immD;
        slotD_o.rs1       = instrD.rs1;
        slotD_o.rs2       = instrD.rs2;
        slotD_o.rd        = instrD.rd;
        slotD_o.regWrite  = validD && writesRd(instrD.opcode);
        slotD_o.predTaken = predTakenD;
        slotD_o.phtIndex  = phtIndexD;

        // Slot 2 never carries a prediction
        slot2D_o.valid     = valid2D;
        slot2D_o.instr     = instr2D;
        slot2D_o.pc        = pc2D;
        slot2D_o.imm       = imm2D;
        slot2D_o.rs1       = instr2D.rs1;
        slot2D_o.rs2       = instr2D.rs2;
        slot2D_o.rd        = instr2D.rd;
        slot2D_o.regWrite  = valid2D && writesRd(instr2D.opcode);
        slot2D_o.predTaken = 1'b0;
        slot2D_o.phtIndex  = '0;
    end

endmodule

/* design/dualIssueFrontEnd.sv */
//**************************************************
// Dual-issue front end
// PC, next-PC select, mispredict and decode
//**************************************************
`timescale 1ns/1ps
`include "frontEnd_defines.svh"

module dualIssueFrontEnd
    import rvIsaPkg::*;
    import frontEndPkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  instrFieldsT      instrF_i,
    input  instrFieldsT      instrF2_i,
    input  logic             stallF_i,
    input  logic             stallD_i,
    input  logic             flushD_i,
    input  resolveT          resolve_i,
    output logic [`XLEN-1:0] pcF_o,
    output logic             mispredict_o,
    output decodedSlotT      slotD_o,
    output decodedSlotT      slot2D_o
);

    predictionT       predF;
    logic             pairBreak;
    logic [`XLEN-1:0] redirectPc;
    logic [`XLEN-1:0] nextPc;

    // Wrong direction on a branch, or a jump the BTB missed
    always_comb begin
        mispredict_o = 1'b0;
        if (resolve_i.valid) begin
            if (resolve_i.kind == kindCond) begin
                mispredict_o = (resolve_i.actualTaken != resolve_i.predTaken);
            end else if (resolve_i.kind == kindJump) begin
                mispredict_o = !resolve_i.predTaken;
            end
        end
    end

    assign redirectPc = resolve_i.actualTaken ? resolve_i.target : resolve_i.pc + `XLEN'd4;

    always_comb begin
        if (mispredict_o) begin
            nextPc = redirectPc;
        end else if (predF.taken) begin
            nextPc = predF.target;
        end else if (pairBreak) begin
            nextPc = pcF_o + `XLEN'd4;
        end else begin
            nextPc = pcF_o + `XLEN'd8;
        end
    end

    // Redirect is taken even while fetch is stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= `PC_START;
        end else if (!stallF_i || mispredict_o) begin
            pcF_o <= nextPc;
        end
    end

    branchPredictor predictor (
        .clk            (clk),
        .reset          (reset),
        .pcF_i          (pcF_o),
        .opF_i          (instrF_i.opcode),
        .fetchAdvance_i (!stallF_i),
        .resolve_i      (resolve_i),
        .mispredict_i   (mispredict_o),
        .predF_o        (predF)
    );

    issuePairCheck pairCheck (
        .instrF_i     (instrF_i),
        .instrF2_i    (instrF2_i),
        .predTakenF_i (predF.taken),
        .pairBreak_o  (pairBreak)
    );

    decodeStage decode (
        .clk         (clk),
        .reset       (reset),
        .stallD_i    (stallD_i),
        .flushD_i    (flushD_i),
        .pairBreak_i (pairBreak),
        .instrF_i    (instrF_i),
        .instrF2_i   (instrF2_i),
        .pcF_i       (pcF_o),
        .predF_i     (predF),
        .slotD_o     (slotD_o),
        .slot2D_o    (slot2D_o)
    );

endmodule

/* tests/frontEndModel.svh */
//**************************************************
// Front end reference model
// PC, predictor state and decode slot rules
//**************************************************
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

typedef struct packed {
    logic        valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] imm;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        regWrite;
    logic        predTaken;
    logic [4:0]  phtIndex;
} modelSlotT;

logic [31:0] mPc;
logic [4:0]  mGhr;
logic [1:0]  mPht [1 << `GHR_BITS];
logic        mBtbValid [`BTB_ENTRIES];
logic [24:0] mBtbTag [`BTB_ENTRIES];
logic [31:0] mBtbTarget [`BTB_ENTRIES];
modelSlotT   mSlot;
modelSlotT   mSlot2;

function automatic logic modelWrites(logic [6:0] op);
    case (op)
        opLui, opJal, opJalr, opLoad, opItype, opRtype: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// RISC-V immediate with the sign from bit 31
function automatic logic [31:0] modelImm(logic [31:0] w);
    logic [31:0] sx;
    sx = {{20{w[31]}}, 12'h000};
    case (w[6:0])
        opLoad, opItype, opJalr: return sx | w[31:20];
        opStore:  return sx | {w[31:25], w[11:7]};
        opBranch: return sx | {w[7], w[30:25], w[11:8], 1'b0};
        opJal:    return {{12{w[31]}}, 20'h00000} | {w[19:12], w[20], w[30:21], 1'b0};
        opLui:    return w & 32'hFFFF_F000;
        default:  return 32'h0;
    endcase
endfunction

function automatic logic modelPairBreak(logic [31:0] a, logic [31:0] b, logic taken);
    logic writesA;
    logic raw;
    logic waw;
    logic ctrl;
    writesA = modelWrites(a[6:0]) && (a[11:7] != 5'd0);
    raw = writesA && ((b[19:15] == a[11:7]) ||
          (((b[6:0] == opRtype) || (b[6:0] == opStore)) && (b[24:20] == a[11:7])));
    waw = writesA && modelWrites(b[6:0]) && (b[11:7] == a[11:7]);
    ctrl = (b[6:0] == opBranch) || (b[6:0] == opJal) || (b[6:0] == opJalr);
    return raw || waw || taken || ctrl;
endfunction

function automatic logic modelPredTaken(logic [31:0] pc, logic [6:0] op);
    logic [4:0] idx;
    idx = pc[6:2];
    if (!mBtbValid[idx] || (mBtbTag[idx] != pc[31:7])) begin
        return 1'b0;
    end
    if ((op == opJal) || (op == opJalr)) begin
        return 1'b1;
    end
    return (op == opBranch) && mPht[mGhr ^ idx][1];
endfunction

function automatic logic modelMispredict(resolveT r);
    if (!r.valid) begin
        return 1'b0;
    end
    return ((r.kind == kindCond) && (r.actualTaken != r.predTaken)) ||
           ((r.kind == kindJump) && !r.predTaken);
endfunction

task automatic modelReset();
    mPc = `PC_START;
    mGhr = '0;
    mSlot = '0;
    mSlot2 = '0;
    for (int i = 0; i < `BTB_ENTRIES; i++) begin
        mBtbValid[i] = 1'b0;
    end
    for (int i = 0; i < (1 << `GHR_BITS); i++) begin
        mPht[i] = 2'd0;
    end
endtask

// Advances the model by one clock edge
task automatic modelStep(input stepT s);
    resolveT     r;
    logic        mis;
    logic        taken;
    logic        brk;
    logic [4:0]  phtIdx;
    logic [31:0] nextPc;
    r = s.resolve;
    mis = modelMispredict(r);
    taken = modelPredTaken(mPc, s.instr[6:0]);
    brk = modelPairBreak(s.instr, s.instr2, taken);
    phtIdx = mGhr ^ mPc[6:2];
    if (mis) begin
        nextPc = r.actualTaken ? r.target : r.pc + 32'd4;
    end else if (taken) begin
        nextPc = mBtbTarget[mPc[6:2]];
    end else begin
        nextPc = brk ? mPc + 32'd4 : mPc + 32'd8;
    end
    if (s.flushD) begin
        mSlot.valid = 1'b0;
        mSlot2.valid = 1'b0;
    end else if (!s.stallD) begin
        mSlot = '{1'b1, s.instr, mPc, modelImm(s.instr), s.instr[19:15], s.instr[24:20],
                  s.instr[11:7], modelWrites(s.instr[6:0]), taken, phtIdx};
        mSlot2 = '{!brk, s.instr2, mPc + 32'd4, modelImm(s.instr2), s.instr2[19:15],
                   s.instr2[24:20], s.instr2[11:7], modelWrites(s.instr2[6:0]), 1'b0, 5'd0};
    end
    if (mis) begin
        mGhr = '0;
    end else if (!s.stallF && (s.instr[6:0] == opBranch)) begin
        mGhr = {mGhr[3:0], taken};
    end
    if (r.valid && (r.kind != kindJump)) begin
        if (r.actualTaken && (mPht[r.phtIndex] != 2'd3)) begin
            mPht[r.phtIndex] = mPht[r.phtIndex] + 2'd1;
        end else if (!r.actualTaken && (mPht[r.phtIndex] != 2'd0)) begin
            mPht[r.phtIndex] = mPht[r.phtIndex] - 2'd1;
        end
    end
    if (r.valid && r.actualTaken) begin
        mBtbValid[r.pc[6:2]] = 1'b1;
        mBtbTag[r.pc[6:2]] = r.pc[31:7];
        mBtbTarget[r.pc[6:2]] = r.target;
    end
    if (!s.stallF || mis) begin
        mPc = nextPc;
    end
endtask

`endif

/* tests/frontEndTb.sv */
//**************************************************
// Front end testbench
// Table-driven stimulus checked against a model
//**************************************************
`timescale 1ns/1ps
`include "frontEnd_defines.svh"

module frontEndTb
    import rvIsaPkg::*;
    import frontEndPkg::*;
();

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] instr2;
        logic        stallF;
        logic        stallD;
        logic        flushD;
        resolveT     resolve;
    } stepT;

    `include "frontEndModel.svh"

    logic        clk;
    logic        reset;
    logic [31:0] instrWord;
    logic [31:0] instrWord2;
    logic        stallF;
    logic        stallD;
    logic        flushD;
    resolveT     resolve;
    logic [31:0] pcF;
    logic        mispredict;
    decodedSlotT slotD;
    decodedSlotT slot2D;

    stepT   steps[$];
    integer seed;
    int     errors;
    int     checks;
    int     cycles;
    int     cycleLimit;
    int     tableLength;

    dualIssueFrontEnd UUT (
        .clk          (clk),
        .reset        (reset),
        .instrF_i     (instrWord),
        .instrF2_i    (instrWord2),
        .stallF_i     (stallF),
        .stallD_i     (stallD),
        .flushD_i     (flushD),
        .resolve_i    (resolve),
        .pcF_o        (pcF),
        .mispredict_o (mispredict),
        .slotD_o      (slotD),
        .slot2D_o     (slot2D)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] encodeItype(logic [6:0] op, logic [4:0] rd,
                                                logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, op};
    endfunction

    function automatic logic [31:0] encodeAddi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return encodeItype(opItype, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] encodeRtype(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, opRtype};
    endfunction

    function automatic logic [31:0] encodeStore(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encodeBranch(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], opBranch};
    endfunction

    function automatic logic [31:0] encodeJal(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
    endfunction

    function automatic resolveT makeResolve(branchKindT kind, logic [31:0] pc, logic [31:0] target,
                                            logic actual, logic pred, logic [4:0] pht);
        resolveT r;
        r.valid = 1'b1;
        r.kind = kind;
        r.pc = pc;
        r.target = target;
        r.actualTaken = actual;
        r.predTaken = pred;
        r.phtIndex = pht;
        return r;
    endfunction

    task automatic addStep(logic [31:0] a, logic [31:0] b, logic sF, logic sD, logic fD,
                           resolveT r);
        steps.push_back('{a, b, sF, sD, fD, r});
    endtask

    task automatic buildTable();
        // Independent pair, RAW on rs1 and rs2, WAW, then rd zero
        addStep(encodeAddi(1, 0, 1), encodeAddi(2, 0, 2), 0, 0, 0, '0);
        addStep(encodeAddi(3, 0, 5), encodeRtype(4, 3, 1), 0, 0, 0, '0);
        addStep(encodeAddi(5, 0, 7), encodeStore(5, 1, 12'h010), 0, 0, 0, '0);
        addStep(encodeAddi(6, 0, 1), encodeAddi(6, 0, 2), 0, 0, 0, '0);
        addStep(encodeAddi(0, 0, 1), encodeRtype(8, 0, 0), 0, 0, 0, '0);
        // Control flow in slot 2
        addStep(encodeAddi(9, 0, 3), encodeBranch(1, 2, 13'h010), 0, 0, 0, '0);
        addStep(encodeAddi(10, 0, 3), encodeJal(1, 21'h20), 0, 0, 0, '0);
        // Fetch stall, decode stall, flush while stalled
        addStep(encodeAddi(11, 0, 4), encodeAddi(12, 0, 5), 1, 0, 0, '0);
        addStep(encodeAddi(13, 0, 4), encodeAddi(14, 0, 5), 0, 1, 0, '0);
        addStep(encodeAddi(15, 0, 4), encodeAddi(16, 0, 5), 0, 1, 1, '0);
        addStep(`NOP_INSTR, `NOP_INSTR, 0, 0, 0, '0);
        // One slot 1 word per immediate format
        addStep({20'hABCDE, 5'd1, opLui}, `NOP_INSTR, 0, 0, 0, '0);
        addStep(encodeJal(1, 21'h1FFFF0), `NOP_INSTR, 0, 0, 0, '0);
        addStep(encodeItype(opJalr, 1, 2, 12'h804), `NOP_INSTR, 0, 0, 0, '0);
        addStep(encodeItype(opLoad, 3, 2, 12'hFFC), `NOP_INSTR, 0, 0, 0, '0);
        addStep(encodeStore(3, 2, 12'h7F8), `NOP_INSTR, 0, 0, 0, '0);
        addStep(encodeBranch(1, 2, 13'h1FF0), `NOP_INSTR, 0, 0, 0, '0);
        addStep(encodeAddi(4, 0, 12'h800), `NOP_INSTR, 0, 0, 0, '0);
        // Not-taken redirect to pc plus 4
        addStep(`NOP_INSTR, `NOP_INSTR, 0, 0, 0, makeResolve(kindCond, 32'h40, 32'h80, 0, 1, 5));
        // Train the branch at 0x100, then steer fetch there with a missed jump
        addStep(`NOP_INSTR, `NOP_INSTR, 0, 0, 0, makeResolve(kindCond, 32'h100, 32'h200, 1, 0, 0));
        addStep(`NOP_INSTR, `NOP_INSTR, 0, 0, 0, makeResolve(kindCond, 32'h100, 32'h200, 1, 0, 0));
        addStep(`NOP_INSTR, `NOP_INSTR, 0, 0, 0, makeResolve(kindJump, 32'h84, 32'h100, 1, 0, 0));
        addStep(encodeBranch(1, 2, 13'h100), encodeAddi(5, 0, 1), 0, 0, 0, '0);
        addStep(`NOP_INSTR, `NOP_INSTR, 0, 0, 0, '0);
    endtask

    task automatic appendRandomPairs();
        logic [31:0] r;
        logic [31:0] second;
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            // Slot 1 writes x0 to x15, slot 2 only touches x16 to x31
            if (r[22]) begin
                second = encodeRtype({1'b1, r[7:4]}, {1'b1, r[11:8]}, {1'b1, r[15:12]});
            end else begin
                second = encodeAddi({1'b1, r[7:4]}, {1'b1, r[11:8]}, r[31:20]);
            end
            addStep(encodeAddi({1'b0, r[3:0]}, r[20:16], r[31:20]), second, 0, 0, 0, '0);
        end
        addStep(`NOP_INSTR, `NOP_INSTR, 0, 0, 0, '0);
    endtask

    task automatic checkValue(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR time=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic checkOutputs(input stepT s);
        checkValue("pcF_o", mPc, pcF);
        checkValue("mispredict_o", modelMispredict(s.resolve), mispredict);
        checkValue("slotD_o.valid", mSlot.valid, slotD.valid);
        if (mSlot.valid) begin
            checkValue("slotD_o.instr", mSlot.instr, slotD.instr);
            checkValue("slotD_o.pc", mSlot.pc, slotD.pc);
            checkValue("slotD_o.imm", mSlot.imm, slotD.imm);
            checkValue("slotD_o.rs1", mSlot.rs1, slotD.rs1);
            checkValue("slotD_o.rs2", mSlot.rs2, slotD.rs2);
            checkValue("slotD_o.rd", mSlot.rd, slotD.rd);
            checkValue("slotD_o.regWrite", mSlot.regWrite, slotD.regWrite);
            checkValue("slotD_o.predTaken", mSlot.predTaken, slotD.predTaken);
            checkValue("slotD_o.phtIndex", mSlot.phtIndex, slotD.phtIndex);
        end
        checkValue("slot2D_o.valid", mSlot2.valid, slot2D.valid);
        if (mSlot2.valid) begin
            checkValue("slot2D_o.instr", mSlot2.instr, slot2D.instr);
            checkValue("slot2D_o.pc", mSlot2.pc, slot2D.pc);
            checkValue("slot2D_o.imm", mSlot2.imm, slot2D.imm);
            checkValue("slot2D_o.rs1", mSlot2.rs1, slot2D.rs1);
            checkValue("slot2D_o.rs2", mSlot2.rs2, slot2D.rs2);
            checkValue("slot2D_o.rd", mSlot2.rd, slot2D.rd);
            checkValue("slot2D_o.regWrite", mSlot2.regWrite, slot2D.regWrite);
            checkValue("slot2D_o.predTaken", mSlot2.predTaken, slot2D.predTaken);
            checkValue("slot2D_o.phtIndex", mSlot2.phtIndex, slot2D.phtIndex);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        instrWord = `NOP_INSTR;
        instrWord2 = `NOP_INSTR;
        stallF = 1'b0;
        stallD = 1'b0;
        flushD = 1'b0;
        resolve = '0;
        seed = 25;
        errors = 0;
        checks = 0;
        cycles = 0;
        buildTable();
        tableLength = steps.size();
        appendRandomPairs();
        cycleLimit = tableLength + 40 + 16 + 20;
        modelReset();
        repeat (16) @(posedge clk);
        #2;
        // Reset state against the freshly reset model
        checkOutputs('0);
        reset = 1'b0;
        foreach (steps[i]) begin
            instrWord = steps[i].instr;
            instrWord2 = steps[i].instr2;
            stallF = steps[i].stallF;
            stallD = steps[i].stallD;
            flushD = steps[i].flushD;
            resolve = steps[i].resolve;
            #16;
            checkOutputs(steps[i]);
            modelStep(steps[i]);
            @(posedge clk);
            #2;
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+design
+incdir+tests
design/rvIsaPkg.sv
design/frontEndPkg.sv
design/branchPredictor.sv
design/issuePairCheck.sv
design/immDecode.sv
design/decodeStage.sv
design/dualIssueFrontEnd.sv
tests/frontEndTb.sv
